// File: hw/common_pkg.sv
package common_pkg;

    // machine word, rv32
    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;   // pc, instruction, immediate

    // bubble marker, never a real fetch address
    localparam word_t NOP_PC = '1;

    // addi x0, x0, 0
    localparam word_t NOP_IR = 32'h0000_0013;

    // instruction memory geometry
    localparam int IMEM_WORDS = 64;
    localparam int IMEM_AW    = 6;     // log2(IMEM_WORDS), pc bits 7:2

endpackage

// File: hw/isa_pkg.sv
package isa_pkg;

    // base opcodes handled by the front end
    typedef enum logic [6:0] {
        OP_OTHER = 7'b0000000,   // anything not listed below
        LOAD     = 7'b0000011,
        OP_IMM   = 7'b0010011,
        AUIPC    = 7'b0010111,
        STORE    = 7'b0100011,
        OP       = 7'b0110011,
        LUI      = 7'b0110111,
        JAL      = 7'b1101111
    } opcode_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;     // low immediate bits sit where rd would be
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    // jal immediate is scrambled across the upper bits
    typedef struct packed {
        logic        imm_20;
        logic [9:0]  imm_10_1;
        logic        imm_11;
        logic [7:0]  imm_19_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } j_fmt_t;

    // one instruction word, every format view over the same bits
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        u_fmt_t u;
        j_fmt_t j;
    } instr_t;

endpackage

// File: hw/fetch_bus.sv
// fetch to decode link, payload forward and redirect back
interface fetch_bus;
    import common_pkg::*;

    word_t pc;          // bubble when NOP_PC
    word_t ir;          // instruction at pc
    word_t jmp_addr;    // redirect target
    logic  jmp_valid;   // one cycle pulse on a taken jal
    logic  ready;       // decode not stalled

    // fetch side
    modport stage_if (
        output pc,
        output ir,
        input  jmp_addr,
        input  jmp_valid,
        input  ready
    );

    // decode side
    modport stage_id (
        input  pc,
        input  ir,
        output jmp_addr,
        output jmp_valid,
        output ready
    );

endinterface

// File: hw/imem.sv
module imem (
    input  logic                            clk_i,
    input  logic                            we_i,      // load strobe
    input  logic [common_pkg::IMEM_AW-1:0]  waddr_i,   // word index
    input  common_pkg::word_t               wdata_i,
    input  common_pkg::word_t               raddr_i,   // byte address from fetch
    output common_pkg::word_t               rdata_o    // valid one clock after raddr_i
);
    import common_pkg::*;

    word_t mem [IMEM_WORDS];

    logic [IMEM_AW-1:0] ridx;

    // byte address to word index, upper bits ignored so fetch wraps at 256 bytes
    assign ridx = raddr_i[IMEM_AW+1:2];

    // program load port
    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // registered read, old data on a same-cycle write
    always_ff @(posedge clk_i) begin
        rdata_o <= mem[ridx];
    end

    // fetch only ever asks for whole words
    a_raddr_aligned: assert property (@(posedge clk_i) raddr_i[1:0] == 2'b00)
        else $error("imem: misaligned read address %h", raddr_i);

endmodule

// File: hw/cpu_if.sv
module cpu_if (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              halt_i,        // freeze fetch
    output common_pkg::word_t imem_addr_o,   // next pc read this cycle
    input  common_pkg::word_t imem_data_i,   // word at pc_q
    fetch_bus.stage_if        bus
);
    import common_pkg::*;

    word_t pc_q;   // address whose data arrives this cycle
    word_t pc_d;   // address requested now

    // next pc selection
    // a jump outranks halt so the redirect is never dropped
    always_comb begin
        priority if (reset_i) begin
            pc_d = '0;
        end else if (bus.jmp_valid) begin
            pc_d = bus.jmp_addr;
        end else if (halt_i || !bus.ready) begin
            pc_d = pc_q;          // halt or back-pressure re-reads the same word
        end else begin
            pc_d = pc_q + 32'd4;
        end
    end

    assign imem_addr_o = pc_d;    // memory latency lines up with pc_q

    always_ff @(posedge clk_i) begin
        pc_q <= pc_d;             // reset comes in through pc_d
    end

    // pc/ir pair for decode
    always_ff @(posedge clk_i) begin
        if (reset_i || bus.jmp_valid) begin
            bus.pc <= NOP_PC;     // squash the word behind a jal
            bus.ir <= NOP_IR;
        end else if (bus.ready) begin
            if (halt_i) begin
                // current pair consumed with nothing new behind it
                bus.pc <= NOP_PC;
                bus.ir <= NOP_IR;
            end else begin
                bus.pc <= pc_q;
                bus.ir <= imem_data_i;
            end
        end
        // held pair is seen again by decode when not ready
    end

    // jal targets from decode must stay on word boundaries
    a_pc_aligned: assert property (
        @(posedge clk_i) disable iff (reset_i) pc_q[1:0] == 2'b00
    ) else $error("cpu_if: misaligned pc %h", pc_q);

endmodule

// File: hw/cpu_id.sv
module cpu_id (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              stall_i,        // back-pressure from later stages
    fetch_bus.stage_id        bus,
    output logic              dec_valid_o,
    output common_pkg::word_t dec_pc_o,
    output isa_pkg::opcode_e  dec_opcode_o,
    output logic [4:0]        dec_rd_o,
    output logic [4:0]        dec_rs1_o,
    output logic [4:0]        dec_rs2_o,
    output common_pkg::word_t dec_imm_o
);
    import common_pkg::*;
    import isa_pkg::*;

    instr_t     ir;
    opcode_e    opc;
    logic [4:0] rd, rs1, rs2;
    word_t      imm;
    word_t      imm_j;
    logic       bubble;

    assign ir     = bus.ir;
    assign bubble = (bus.pc == NOP_PC);

    // j-type offset also feeds the redirect adder
    assign imm_j = {{11{ir.j.imm_20}}, ir.j.imm_20, ir.j.imm_19_12,
                    ir.j.imm_11, ir.j.imm_10_1, 1'b0};

    // field split per format with unused fields forced to zero
    always_comb begin
        opc = OP_OTHER;
        rd  = '0;
        rs1 = '0;
        rs2 = '0;
        imm = '0;
        case (ir.r.opcode)
            OP: begin                      // r-type without immediate
                opc = OP;
                rd  = ir.r.rd;
                rs1 = ir.r.rs1;
                rs2 = ir.r.rs2;
            end
            OP_IMM, LOAD: begin            // i-type
                opc = opcode_e'(ir.i.opcode);
                rd  = ir.i.rd;
                rs1 = ir.i.rs1;
                imm = {{20{ir.i.imm_11_0[11]}}, ir.i.imm_11_0};
            end
            STORE: begin                   // s-type without rd
                opc = STORE;
                rs1 = ir.s.rs1;
                rs2 = ir.s.rs2;
                imm = {{20{ir.s.imm_11_5[6]}}, ir.s.imm_11_5, ir.s.imm_4_0};
            end
            LUI, AUIPC: begin              // u-type
                opc = opcode_e'(ir.u.opcode);
                rd  = ir.u.rd;
                imm = {ir.u.imm_31_12, 12'h000};
            end
            JAL: begin
                opc = JAL;
                rd  = ir.j.rd;
                imm = imm_j;
            end
            default: ;                     // unknown opcode leaves everything zero
        endcase
    end

    // back to fetch
    assign bus.ready     = !stall_i;
    assign bus.jmp_valid = !stall_i && !bubble && (ir.j.opcode == JAL);
    assign bus.jmp_addr  = bus.pc + imm_j;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            dec_valid_o <= 1'b0;
            dec_pc_o    <= NOP_PC;
        end else begin
            dec_valid_o <= !stall_i && !bubble;
            if (!stall_i) begin
                dec_pc_o <= bus.pc;
            end
        end
    end

    // decoded payload
    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            dec_opcode_o <= opc;
            dec_rd_o     <= rd;
            dec_rs1_o    <= rs1;
            dec_rs2_o    <= rs2;
            dec_imm_o    <= imm;
        end
    end

    // fetch must squash the word behind a taken jal
    a_jmp_squash: assert property (@(posedge clk_i) bus.jmp_valid |=> bubble)
        else $error("cpu_id: no bubble after jump");

endmodule

// File: hw/cpu_frontend.sv
module cpu_frontend (
    input  logic                            clk_i,
    input  logic                            reset_i,
    input  logic                            halt_i,
    input  logic                            stall_i,
    input  logic                            imem_we_i,
    input  logic [common_pkg::IMEM_AW-1:0]  imem_waddr_i,
    input  common_pkg::word_t               imem_wdata_i,
    output logic                            dec_valid_o,
    output common_pkg::word_t               dec_pc_o,
    output isa_pkg::opcode_e                dec_opcode_o,
    output logic [4:0]                      dec_rd_o,
    output logic [4:0]                      dec_rs1_o,
    output logic [4:0]                      dec_rs2_o,
    output common_pkg::word_t               dec_imm_o
);
    import common_pkg::*;

    word_t imem_addr;   // fetch request
    word_t imem_data;   // one clock later

    fetch_bus fbus ();

    imem imem_inst (
        .clk_i   (clk_i),
        .we_i    (imem_we_i),
        .waddr_i (imem_waddr_i),
        .wdata_i (imem_wdata_i),
        .raddr_i (imem_addr),
        .rdata_o (imem_data)
    );

    cpu_if cpu_if_inst (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .halt_i      (halt_i),
        .imem_addr_o (imem_addr),
        .imem_data_i (imem_data),
        .bus         (fbus.stage_if)
    );

    cpu_id cpu_id_inst (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .stall_i      (stall_i),
        .bus          (fbus.stage_id),
        .dec_valid_o  (dec_valid_o),
        .dec_pc_o     (dec_pc_o),
        .dec_opcode_o (dec_opcode_o),
        .dec_rd_o     (dec_rd_o),
        .dec_rs1_o    (dec_rs1_o),
        .dec_rs2_o    (dec_rs2_o),
        .dec_imm_o    (dec_imm_o)
    );

endmodule

// File: sim/frontend_checker.sv
module frontend_checker (
    input  logic                           clk_i,
    input  logic                           reset_i,
    input  logic                           imem_we_i,     // load port snoop
    input  logic [common_pkg::IMEM_AW-1:0] imem_waddr_i,
    input  common_pkg::word_t              imem_wdata_i,
    input  logic                           dec_valid_i,
    input  common_pkg::word_t              dec_pc_i,
    input  isa_pkg::opcode_e               dec_opcode_i,
    input  logic [4:0]                     dec_rd_i,
    input  logic [4:0]                     dec_rs1_i,
    input  logic [4:0]                     dec_rs2_i,
    input  common_pkg::word_t              dec_imm_i,
    output int                             dec_count_o,   // decodes since reset
    output int                             err_count_o    // mismatches over the whole run
);
    timeunit 1ns;
    timeprecision 1ps;
    import common_pkg::*;
    import isa_pkg::*;

    word_t      mem [IMEM_WORDS];   // shadow of the program
    word_t      ref_pc;             // next pc expected from decode
    word_t      w;
    opcode_e    e_opc;
    logic [4:0] e_rd, e_rs1, e_rs2;
    word_t      e_imm;
    logic       reset_q = 1'b0;
    int         dec_cnt = 0;
    int         err_cnt = 0;

    assign dec_count_o = dec_cnt;
    assign err_count_o = err_cnt;

    // field split straight from the rv32i encoding tables
    function automatic void ref_decode(input word_t iw, output opcode_e opc,
                                       output logic [4:0] rd, output logic [4:0] rs1,
                                       output logic [4:0] rs2, output word_t imm);
        opc = OP_OTHER;
        rd  = 5'd0;
        rs1 = 5'd0;
        rs2 = 5'd0;
        imm = 32'd0;
        case (iw[6:0])
            OP: begin
                opc = OP;
                rd  = iw[11:7];
                rs1 = iw[19:15];
                rs2 = iw[24:20];
            end
            OP_IMM, LOAD: begin
                opc = (iw[6:0] == LOAD) ? LOAD : OP_IMM;
                rd  = iw[11:7];
                rs1 = iw[19:15];
                imm = {{20{iw[31]}}, iw[31:20]};
            end
            STORE: begin
                opc = STORE;        // no rd
                rs1 = iw[19:15];
                rs2 = iw[24:20];
                imm = {{20{iw[31]}}, iw[31:25], iw[11:7]};
            end
            LUI, AUIPC: begin
                opc = (iw[6:0] == LUI) ? LUI : AUIPC;
                rd  = iw[11:7];
                imm = {iw[31:12], 12'h000};
            end
            JAL: begin
                opc = JAL;
                rd  = iw[11:7];
                imm = {{11{iw[31]}}, iw[31], iw[19:12], iw[20], iw[30:21], 1'b0};
            end
            default: ;              // unknown opcode stays all zero
        endcase
    endfunction

    task automatic check_field(input string field, input word_t exp, input word_t got);
        if (got !== exp) begin
            $display("MISMATCH at %0d ns: %s expected %h got %h (ref pc %h)",
                     $time, field, exp, got, ref_pc);
            err_cnt++;
        end
    endtask

    // dut outputs settle half a cycle before the negedge
    always @(negedge clk_i) begin
        if (imem_we_i) begin
            mem[imem_waddr_i] = imem_wdata_i;
        end
        if (reset_i) begin
            ref_pc  = 32'd0;        // fetch restarts at zero
            dec_cnt = 0;
            if (reset_q) begin      // at least one reset edge seen
                check_field("valid in reset", 32'd0, 32'(dec_valid_i));
                check_field("pc in reset", NOP_PC, dec_pc_i);
            end
        end else if (dec_valid_i) begin
            w = mem[ref_pc[IMEM_AW+1:2]];   // wraps every 256 bytes
            ref_decode(w, e_opc, e_rd, e_rs1, e_rs2, e_imm);
            check_field("pc", ref_pc, dec_pc_i);
            check_field("opcode", 32'(e_opc), 32'(dec_opcode_i));
            check_field("rd", 32'(e_rd), 32'(dec_rd_i));
            check_field("rs1", 32'(e_rs1), 32'(dec_rs1_i));
            check_field("rs2", 32'(e_rs2), 32'(dec_rs2_i));
            check_field("imm", e_imm, dec_imm_i);
            // word after a jal is skipped
            ref_pc = (e_opc == JAL) ? ref_pc + e_imm : ref_pc + 32'd4;
            dec_cnt++;
        end
        reset_q = reset_i;
    end

endmodule

// File: sim/tb_frontend.sv
module tb_frontend;
    timeunit 1ns;
    timeprecision 1ps;
    import common_pkg::*;
    import isa_pkg::*;

    localparam int N_TESTS      = 5;
    localparam int N_INSTR      = 300;                          // decodes per test
    localparam int RESET_CYCLES = 5;
    localparam int LOAD_CYCLES  = IMEM_WORDS + RESET_CYCLES + 2;
    localparam int CYCLE_LIMIT  = N_TESTS * (N_INSTR * 6 + LOAD_CYCLES);

    logic               clk = 1'b0;
    logic               reset;
    logic               halt;
    logic               stall;
    logic               imem_we;
    logic [IMEM_AW-1:0] imem_waddr;
    word_t              imem_wdata;
    logic               dec_valid;
    word_t              dec_pc;
    opcode_e            dec_opcode;
    logic [4:0]         dec_rd, dec_rs1, dec_rs2;
    word_t              dec_imm;
    int                 dec_count;
    int                 err_count;
    int                 total_dec = 0;
    int                 total_err = 0;
    int                 cycles    = 0;
    logic [31:0]        lfsr      = 32'h4d06807a;

    always #50 clk = ~clk;      // 100 ns period

    cpu_frontend cpu_frontend_inst (
        .clk_i (clk), .reset_i (reset), .halt_i (halt), .stall_i (stall),
        .imem_we_i (imem_we), .imem_waddr_i (imem_waddr), .imem_wdata_i (imem_wdata),
        .dec_valid_o (dec_valid), .dec_pc_o (dec_pc), .dec_opcode_o (dec_opcode),
        .dec_rd_o (dec_rd), .dec_rs1_o (dec_rs1), .dec_rs2_o (dec_rs2),
        .dec_imm_o (dec_imm)
    );

    frontend_checker frontend_checker_inst (
        .clk_i (clk), .reset_i (reset), .imem_we_i (imem_we),
        .imem_waddr_i (imem_waddr), .imem_wdata_i (imem_wdata),
        .dec_valid_i (dec_valid), .dec_pc_i (dec_pc), .dec_opcode_i (dec_opcode),
        .dec_rd_i (dec_rd), .dec_rs1_i (dec_rs1), .dec_rs2_i (dec_rs2),
        .dec_imm_i (dec_imm), .dec_count_o (dec_count), .err_count_o (err_count)
    );

    // galois form, right shift
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hB4BCD35C) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr = lfsr_next(lfsr);    // one step per bit
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // random word for slot k, jal taken with odds jal_lim/16
    function automatic word_t make_word(input int k, input int jal_lim);
        word_t   fields;
        word_t   target;
        word_t   off;
        word_t   w;
        opcode_e opc;
        fields = take_bits(25);
        if (take_bits(4) < word_t'(jal_lim)) begin
            target = take_bits(6);                       // any word in memory
            off    = (target - word_t'(k)) << 2;
            w      = {off[20], off[10:1], off[11], off[19:12], fields[4:0], JAL};
        end else begin
            case (take_bits(3) % 32'd6)
                32'd0:   opc = OP;
                32'd1:   opc = OP_IMM;
                32'd2:   opc = LOAD;
                32'd3:   opc = STORE;
                32'd4:   opc = LUI;
                default: opc = AUIPC;
            endcase
            w = {fields[24:0], opc};
        end
        return w;
    endfunction

    task automatic load_program(input int jal_lim);
        for (int k = 0; k < IMEM_WORDS; k++) begin
            imem_we    = 1'b1;
            imem_waddr = IMEM_AW'(k);
            imem_wdata = make_word(k, jal_lim);
            @(posedge clk);
            #5;
        end
        imem_we = 1'b0;
    endtask

    task automatic run_test(input int num, input string name, input int jal_lim,
                            input bit stall_en, input bit halt_en);
        int err_start;
        int decoded;
        @(posedge clk);
        #5;
        reset     = 1'b1;
        stall     = 1'b0;
        halt      = 1'b0;
        err_start = err_count;
        load_program(jal_lim);               // loaded under reset
        repeat (RESET_CYCLES) @(posedge clk);
        #5;
        reset = 1'b0;
        while (dec_count < N_INSTR) begin
            @(posedge clk);
            #5;
            stall = stall_en && (take_bits(2) == 32'd0);   // about 1 in 4
            halt  = halt_en && (take_bits(3) == 32'd0);    // about 1 in 8
        end
        decoded = dec_count;
        stall   = 1'b0;
        halt    = 1'b0;
        reset   = 1'b1;
        total_dec += decoded;
        total_err += err_count - err_start;
        $display("test %0d %s: %0d decoded, %0d mismatches",
                 num, name, decoded, err_count - err_start);
    endtask

    // run limit from test length
    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: decode stalled, %0d cycles without finishing", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        reset      = 1'b1;
        halt       = 1'b0;
        stall      = 1'b0;
        imem_we    = 1'b0;
        imem_waddr = '0;
        imem_wdata = '0;
        run_test(1, "sequential, no jumps", 0, 1'b0, 1'b0);
        run_test(2, "mixed formats", 2, 1'b0, 1'b0);
        run_test(3, "jal redirects", 6, 1'b0, 1'b0);
        run_test(4, "random stall", 3, 1'b1, 1'b0);
        run_test(5, "halt with stall and jumps", 3, 1'b1, 1'b1);
        $display("summary: %0d tests, %0d decoded, %0d mismatches",
                 N_TESTS, total_dec, total_err);
        if (total_err == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: sources.f
hw/common_pkg.sv
hw/isa_pkg.sv
hw/fetch_bus.sv
hw/imem.sv
hw/cpu_if.sv
hw/cpu_id.sv
hw/cpu_frontend.sv
sim/frontend_checker.sv
sim/tb_frontend.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the front end testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_frontend -f sources.f \
    -o tb_frontend_sim || { echo "build failed"; exit 1; }

out="$(./obj_dir/tb_frontend_sim 2>&1)"
echo "$out"
grep -qx "Test OK" <<< "$out" && exit 0 || exit 1
